// ==== include/tcu_config.svh ====
/*
 * Tensor dot-product unit feature switches
 * Each switch is a 1-bit constant that enables one datapath feature
 */
`ifndef TCU_CONFIG_SVH
`define TCU_CONFIG_SVH

// Set to 1'b1 to keep the INT8 lane products
`define TCU_INT_ENABLE 1'b1

`endif

// ==== hw/tcu_pkg.sv ====
/*
 * Tensor dot-product unit package
 * Format codes, term widths, exception and class records,
 * the dual-view operand word and the format helper
 */
package tcu_pkg;

    // ========================================================================
    // Format codes
    // ========================================================================
    localparam logic [3:0] TCU_FP16_ID = 4'd1;
    localparam logic [3:0] TCU_I8_ID   = 4'd8;

    // ========================================================================
    // Datapath widths
    // ========================================================================
    // Lane terms per request
    localparam int TCK   = 4;
    // Term exponent wide enough for a rebased FP32 C
    localparam int EXP_W = 10;
    // Signed term significand
    localparam int SIG_W = 25;
    // Product significand and accumulator widths set the C exponent offset
    localparam int W     = 22;
    localparam int WA    = 28;
    localparam int SUM_W = 32;
    // Request tag
    localparam int ID_W  = 8;

    // Term bundle FIFO
    localparam int FIFO_DEPTH = 4;
    // fmt + req_id + c_val + per-lane sig, exp and exception bits
    localparam int TERM_W     = 4 + ID_W + 32 + TCK * (SIG_W + EXP_W + 3);

    // ========================================================================
    // Types
    // ========================================================================
    // Special-case summary of one term or of the whole result
    typedef struct packed {
        logic is_nan;
        logic is_inf;
        logic sign;
    } fedp_excep_t;

    // Field classification from tcu_classifier
    typedef struct packed {
        logic is_zero;
        logic is_sub;
        logic is_inf;
        logic is_nan;
    } fedp_class_t;

    // One operand word seen as two FP16 halves or as four INT8 bytes
    typedef union packed {
        logic [1:0][15:0] h;
        logic [3:0][7:0]  b;
    } tcu_word_u;

    // Integer formats sit in the upper half of the code space
    function automatic logic tcu_fmt_is_int(input logic [3:0] fmt);
        return fmt[3];
    endfunction

endpackage

// ==== hw/tcu_term_if.sv ====
/*
 * Term bundle link
 * Carries lane significands, exponents and exceptions plus the request
 * context between pipeline stages under a valid/ready handshake
 */
`timescale 1ns/1ps

interface tcu_term_if;
    import tcu_pkg::*;

    logic                             valid;
    logic                             ready;
    logic [3:0]                       fmt;
    logic [ID_W-1:0]                  req_id;
    logic [31:0]                      c_val;
    // Two's complement significand per lane
    logic [TCK-1:0][SIG_W-1:0]        sig;
    logic [TCK-1:0][EXP_W-1:0]        exp;
    fedp_excep_t [TCK-1:0]            exc;

    // Sending stage owns everything but ready
    modport producer (
        output valid, fmt, req_id, c_val, sig, exp, exc,
        input  ready
    );

    modport consumer (
        input  valid, fmt, req_id, c_val, sig, exp, exc,
        output ready
    );

endinterface

// ==== hw/tcu_classifier.sv ====
/*
 * Floating-point field classifier
 * Flags an exponent/mantissa pair as zero, subnormal, infinity or NaN
 */
`timescale 1ns/1ps

module tcu_classifier #(
    parameter int exp_w = 5,
    parameter int man_w = 10
) (
    input  logic [exp_w-1:0]   exp,
    input  logic [man_w-1:0]   man,
    output tcu_pkg::fedp_class_t cls
);

    logic exp_zero;
    logic exp_max;
    logic man_zero;

    assign exp_zero = (exp == '0);
    // All-ones exponent marks the special encodings
    assign exp_max  = &exp;
    assign man_zero = (man == '0);

    assign cls.is_zero = exp_zero & man_zero;
    assign cls.is_sub  = exp_zero & ~man_zero;
    assign cls.is_inf  = exp_max & man_zero;
    assign cls.is_nan  = exp_max & ~man_zero;

endmodule

// ==== hw/tcu_mul_lanes.sv ====
/*
 * Multiplier lane stage
 * Forms four lane terms per request, FP16 products with exponent and
 * exception flags or INT8 pair sums, and registers them with the context
 */
`timescale 1ns/1ps
`include "tcu_config.svh"

module tcu_mul_lanes (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [3:0]               fmt,
    input  logic [tcu_pkg::ID_W-1:0] req_id,
    input  logic [63:0]              a,
    input  logic [63:0]              b,
    input  logic [31:0]              c_val,
    tcu_term_if.producer             lane_if
);
    import tcu_pkg::*;

    tcu_word_u [1:0]           a_w;
    tcu_word_u [1:0]           b_w;
    fedp_class_t [TCK-1:0]     cls_a;
    fedp_class_t [TCK-1:0]     cls_b;
    logic [TCK-1:0][SIG_W-1:0] f_sig;
    logic [TCK-1:0][EXP_W-1:0] f_exp;
    fedp_excep_t [TCK-1:0]     f_exc;
    logic [TCK-1:0][SIG_W-1:0] i_sig;
    logic                      is_int;
    logic                      accept;

    // Same 64 bits, decoded per format below
    assign a_w = a;
    assign b_w = b;

    assign is_int = `TCU_INT_ENABLE && tcu_fmt_is_int(fmt);

    // ========================================================================
    // Per-lane arithmetic
    // ========================================================================
    for (genvar i = 0; i < TCK; i++) begin : g_lane
        logic [15:0]        ha;
        logic [15:0]        hb;
        logic [W-1:0]       prod;
        logic               a_zero;
        logic               b_zero;
        logic               p_nan;
        logic signed [15:0] p_lo;
        logic signed [15:0] p_hi;

        // FP16 lane i is half i of the vector
        assign ha = a_w[i/2].h[i%2];
        assign hb = b_w[i/2].h[i%2];

        tcu_classifier #(
            .exp_w (5),
            .man_w (10)
        ) u_cls_a (
            .exp (ha[14:10]),
            .man (ha[9:0]),
            .cls (cls_a[i])
        );

        tcu_classifier #(
            .exp_w (5),
            .man_w (10)
        ) u_cls_b (
            .exp (hb[14:10]),
            .man (hb[9:0]),
            .cls (cls_b[i])
        );

        // Subnormals flush to zero
        assign a_zero = cls_a[i].is_zero | cls_a[i].is_sub;
        assign b_zero = cls_b[i].is_zero | cls_b[i].is_sub;

        // 11x11 significand product with hidden bits
        assign prod = {1'b1, ha[9:0]} * {1'b1, hb[9:0]};

        // Signed term carrying the XOR of the operand signs
        assign f_sig[i] = (a_zero | b_zero) ? '0 :
                          (ha[15] ^ hb[15]) ? -SIG_W'(prod) : SIG_W'(prod);
        // Sum of biased exponents
        assign f_exp[i] = (a_zero | b_zero) ? '0 :
                          EXP_W'(ha[14:10]) + EXP_W'(hb[14:10]);

        // NaN in, or Inf times zero
        assign p_nan = cls_a[i].is_nan | cls_b[i].is_nan |
                       (cls_a[i].is_inf & b_zero) | (cls_b[i].is_inf & a_zero);
        assign f_exc[i].is_nan = p_nan;
        assign f_exc[i].is_inf = (cls_a[i].is_inf | cls_b[i].is_inf) & ~p_nan;
        assign f_exc[i].sign   = ha[15] ^ hb[15];

        // INT8 lane i pairs bytes 2i and 2i+1
        assign p_lo = $signed(a_w[i/2].b[(2*i)%4]) * $signed(b_w[i/2].b[(2*i)%4]);
        assign p_hi = $signed(a_w[i/2].b[(2*i+1)%4]) * $signed(b_w[i/2].b[(2*i+1)%4]);
        assign i_sig[i] = SIG_W'(p_lo) + SIG_W'(p_hi);
    end

    // ========================================================================
    // Output register
    // ========================================================================
    // Stage is free when empty or draining this cycle
    assign in_ready = !lane_if.valid || lane_if.ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            lane_if.valid <= 1'b0;
        end else if (accept) begin
            lane_if.valid <= 1'b1;
        end else if (lane_if.ready) begin
            lane_if.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lane_if.fmt    <= fmt;
            lane_if.req_id <= req_id;
            lane_if.c_val  <= c_val;
            lane_if.sig    <= is_int ? i_sig : f_sig;
            // integer terms carry no exponent or special flags
            lane_if.exp    <= is_int ? '0 : f_exp;
            lane_if.exc    <= is_int ? '0 : f_exc;
        end
    end

endmodule

// ==== hw/tcu_term_fifo.sv ====
/*
 * Term bundle FIFO
 * Four-entry circular buffer between the lane stage and the accumulator
 */
`timescale 1ns/1ps

module tcu_term_fifo (
    input  logic         clk,
    input  logic         rst,
    tcu_term_if.consumer lane_if,
    tcu_term_if.producer join_if
);
    import tcu_pkg::*;

    logic [TERM_W-1:0]                   mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]       wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]       rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0]     count;
    logic                                full;
    logic                                wr_en;
    logic                                rd_en;

    assign full  = (count == FIFO_DEPTH);
    assign wr_en = lane_if.valid && lane_if.ready;
    assign rd_en = join_if.valid && join_if.ready;

    // Back-pressure to the lane stage
    assign lane_if.ready = !full;
    assign join_if.valid = (count != '0);

    // Head entry unpacked straight onto the outgoing link
    assign {join_if.fmt, join_if.req_id, join_if.c_val,
            join_if.sig, join_if.exp, join_if.exc} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {lane_if.fmt, lane_if.req_id, lane_if.c_val,
                            lane_if.sig, lane_if.exp, lane_if.exc};
        end
    end

    // Pointers wrap naturally at depth four
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            count <= count + wr_en - rd_en;
        end
    end

    // Full with no drain keeps the write side frozen
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        full && !rd_en |=> full && $stable(wr_ptr));

    // Stalled head entry is held whole for the accumulator
    a_head_stable: assert property (@(posedge clk) disable iff (rst)
        join_if.valid && !join_if.ready |=>
            join_if.valid && $stable(join_if.fmt) && $stable(join_if.req_id) &&
            $stable(join_if.c_val) && $stable(join_if.sig) &&
            $stable(join_if.exp) && $stable(join_if.exc));

endmodule

// ==== hw/tcu_mul_join.sv ====
/*
 * Term join logic
 * Selects lane fields by format, builds the C term at index TCK and
 * reduces lane and C exceptions into one result flag set
 */
`timescale 1ns/1ps
`include "tcu_config.svh"

module tcu_mul_join (
    input  logic [3:0]                                  fmt,
    input  logic [31:0]                                 c_val,
    input  logic [tcu_pkg::TCK-1:0][tcu_pkg::SIG_W-1:0] sig,
    input  logic [tcu_pkg::TCK-1:0][tcu_pkg::EXP_W-1:0] exp,
    input  tcu_pkg::fedp_excep_t [tcu_pkg::TCK-1:0]     exc,
    output logic [tcu_pkg::TCK:0][tcu_pkg::SIG_W-1:0]   sig_out,
    output logic [tcu_pkg::TCK:0][tcu_pkg::EXP_W-1:0]   exp_out,
    output tcu_pkg::fedp_excep_t                        exc_out
);
    import tcu_pkg::*;

    logic [TCK-1:0][SIG_W-1:0] sig_sel;
    logic [TCK-1:0][EXP_W-1:0] exp_sel;
    fedp_excep_t [TCK-1:0]     exc_sel;
    fedp_class_t               cls_c;
    logic                      c_is_int;
    logic                      c_zero;
    logic [SIG_W-1:0]          c_sig;
    logic [EXP_W-1:0]          c_exp;
    logic [TCK-1:0]            pos_inf;
    logic [TCK-1:0]            neg_inf;
    logic                      has_pos;
    logic                      has_neg;

    // ========================================================================
    // Lane path select
    // ========================================================================
    always_comb begin
        case (fmt)
            TCU_FP16_ID: begin
                sig_sel = sig;
                exp_sel = exp;
                exc_sel = exc;
            end
            TCU_I8_ID: begin
                // Pair sums only, no exponent alignment
                sig_sel = `TCU_INT_ENABLE ? sig : '0;
                exp_sel = '0;
                exc_sel = '0;
            end
            default: begin
                sig_sel = '0;
                exp_sel = '0;
                exc_sel = '0;
            end
        endcase
    end

    // ========================================================================
    // C term
    // ========================================================================
    tcu_classifier #(
        .exp_w (8),
        .man_w (23)
    ) u_cls_c (
        .exp (c_val[30:23]),
        .man (c_val[22:0]),
        .cls (cls_c)
    );

    assign c_is_int = tcu_fmt_is_int(fmt);
    // Subnormal C flushes to zero
    assign c_zero   = cls_c.is_zero | cls_c.is_sub;

    // Raw integer, or hidden bit plus sign applied as two's complement
    assign c_sig = c_is_int ? c_val[SIG_W-1:0] :
                   c_zero   ? '0 :
                   c_val[31] ? -SIG_W'({1'b1, c_val[22:0]}) : SIG_W'({1'b1, c_val[22:0]});

    // Rebase onto the product exponent scale
    assign c_exp = (c_is_int || c_zero) ? '0 :
                   EXP_W'(c_val[30:23]) + EXP_W'(WA - 1) - EXP_W'(W - 1) + EXP_W'(128);

    assign sig_out = {c_sig, sig_sel};
    assign exp_out = {c_exp, exp_sel};

    // ========================================================================
    // Exception reduction
    // ========================================================================
    for (genvar i = 0; i < TCK; i++) begin : g_inf
        assign pos_inf[i] = exc_sel[i].is_inf & ~exc_sel[i].sign;
        assign neg_inf[i] = exc_sel[i].is_inf &  exc_sel[i].sign;
    end

    // Integer C never counts as a special value
    assign has_pos = (|pos_inf) | (~c_is_int & cls_c.is_inf & ~c_val[31]);
    assign has_neg = (|neg_inf) | (~c_is_int & cls_c.is_inf &  c_val[31]);

    // Any NaN, or opposite infinities meeting in the sum
    always_comb begin
        exc_out.is_nan = (|{exc_sel[0].is_nan, exc_sel[1].is_nan,
                            exc_sel[2].is_nan, exc_sel[3].is_nan})
                       | (~c_is_int & cls_c.is_nan)
                       | (has_pos & has_neg);
        exc_out.is_inf = (has_pos | has_neg) & ~exc_out.is_nan;
        exc_out.sign   = has_neg & ~has_pos;
    end

endmodule

// ==== hw/tcu_dot_accum.sv ====
/*
 * Dot-product accumulator
 * Joins lane and C terms, aligns them to the largest exponent, adds them
 * and holds the result under the output handshake
 */
`timescale 1ns/1ps

module tcu_dot_accum (
    input  logic                             clk,
    input  logic                             rst,
    tcu_term_if.consumer                     join_if,
    output logic                             out_valid,
    input  logic                             out_ready,
    output logic [tcu_pkg::ID_W-1:0]         out_id,
    output logic signed [tcu_pkg::SUM_W-1:0] out_sum,
    output logic [tcu_pkg::EXP_W-1:0]        out_exp,
    output logic                             out_nan,
    output logic                             out_inf,
    output logic                             out_sign
);
    import tcu_pkg::*;

    logic [TCK:0][SIG_W-1:0]   t_sig;
    logic [TCK:0][EXP_W-1:0]   t_exp;
    fedp_excep_t               t_exc;
    logic                      is_int;
    logic                      xfer;
    logic [EXP_W-1:0]          max_exp;
    logic signed [SUM_W-1:0]   sum;
    logic signed [SUM_W-1:0]   term;

    tcu_mul_join u_join (
        .fmt     (join_if.fmt),
        .c_val   (join_if.c_val),
        .sig     (join_if.sig),
        .exp     (join_if.exp),
        .exc     (join_if.exc),
        .sig_out (t_sig),
        .exp_out (t_exp),
        .exc_out (t_exc)
    );

    assign is_int = tcu_fmt_is_int(join_if.fmt);

    // ========================================================================
    // Alignment and sum
    // ========================================================================
    // Largest exponent over lanes and C
    always_comb begin
        max_exp = '0;
        for (int i = 0; i <= TCK; i++) begin
            if (t_exp[i] > max_exp) max_exp = t_exp[i];
        end
    end

    // Arithmetic right shift truncates toward negative infinity
    always_comb begin
        sum  = '0;
        term = '0;
        for (int i = 0; i <= TCK; i++) begin
            term = SUM_W'($signed(t_sig[i]));
            if (!is_int) term = term >>> (max_exp - t_exp[i]);
            sum = sum + term;
        end
    end

    // ========================================================================
    // Result register
    // ========================================================================
    assign join_if.ready = !out_valid || out_ready;
    assign xfer          = join_if.valid && join_if.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (xfer) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            out_id   <= join_if.req_id;
            out_sum  <= sum;
            out_exp  <= is_int ? '0 : max_exp;
            out_nan  <= t_exc.is_nan;
            out_inf  <= t_exc.is_inf;
            out_sign <= t_exc.sign;
        end
    end

    // Every result start traces back to an accepted bundle
    a_out_from_xfer: assert property (@(posedge clk) disable iff (rst)
        $rose(out_valid) |-> $past(join_if.valid && join_if.ready));

endmodule

// ==== hw/tcu_dot_top.sv ====
/*
 * Tensor dot-product unit top level
 * Lane stage, term FIFO and accumulator behind plain streaming ports
 */
`timescale 1ns/1ps

module tcu_dot_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  logic [3:0]                       in_fmt,
    input  logic [tcu_pkg::ID_W-1:0]         in_id,
    input  logic [63:0]                      in_a,
    input  logic [63:0]                      in_b,
    input  logic [31:0]                      in_c,
    output logic                             out_valid,
    input  logic                             out_ready,
    output logic [tcu_pkg::ID_W-1:0]         out_id,
    output logic signed [tcu_pkg::SUM_W-1:0] out_sum,
    output logic [tcu_pkg::EXP_W-1:0]        out_exp,
    output logic                             out_nan,
    output logic                             out_inf,
    output logic                             out_sign
);

    // Lane stage to FIFO, FIFO to accumulator
    tcu_term_if lane_if ();
    tcu_term_if join_if ();

    tcu_mul_lanes u_lanes (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .fmt      (in_fmt),
        .req_id   (in_id),
        .a        (in_a),
        .b        (in_b),
        .c_val    (in_c),
        .lane_if  (lane_if.producer)
    );

    tcu_term_fifo u_fifo (
        .clk     (clk),
        .rst     (rst),
        .lane_if (lane_if.consumer),
        .join_if (join_if.producer)
    );

    tcu_dot_accum u_accum (
        .clk       (clk),
        .rst       (rst),
        .join_if   (join_if.consumer),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_id    (out_id),
        .out_sum   (out_sum),
        .out_exp   (out_exp),
        .out_nan   (out_nan),
        .out_inf   (out_inf),
        .out_sign  (out_sign)
    );

endmodule

// ==== bench/tcu_dot_tb.sv ====
/*
 * Dot-product unit testbench
 * Replays request vectors from a text file, throttles the result port
 * with random back-pressure and checks every result in request order
 */
`timescale 1ns/1ps

module tcu_dot_tb;
    import tcu_pkg::*;

    localparam int          MAX_VEC = 64;
    localparam int          NAME_W  = 8 * 24;
    localparam logic [31:0] SEED    = 32'd47129;

    logic                    clk;
    logic                    rst;
    logic                    in_valid;
    logic                    in_ready;
    logic [3:0]              in_fmt;
    logic [ID_W-1:0]         in_id;
    logic [63:0]             in_a;
    logic [63:0]             in_b;
    logic [31:0]             in_c;
    logic                    out_valid;
    logic                    out_ready;
    logic [ID_W-1:0]         out_id;
    logic signed [SUM_W-1:0] out_sum;
    logic [EXP_W-1:0]        out_exp;
    logic                    out_nan;
    logic                    out_inf;
    logic                    out_sign;

    // ========================================================================
    // Vector table and scoreboard
    // ========================================================================
    logic [NAME_W-1:0] v_name [MAX_VEC];
    logic [3:0]        v_fmt  [MAX_VEC];
    logic [ID_W-1:0]   v_id   [MAX_VEC];
    logic [63:0]       v_a    [MAX_VEC];
    logic [63:0]       v_b    [MAX_VEC];
    logic [31:0]       v_c    [MAX_VEC];
    logic [31:0]       v_sum  [MAX_VEC];
    logic [EXP_W-1:0]  v_exp  [MAX_VEC];
    logic [2:0]        v_flag [MAX_VEC];

    int          num_vec;
    int          sent;
    int          received;
    int          head;
    int          cycles;
    int          cycle_limit = 200;
    // Table index of every accepted request in acceptance order
    int          exp_q [$];
    logic [31:0] rng_state;

    tcu_dot_top DUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_fmt    (in_fmt),
        .in_id     (in_id),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_c      (in_c),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_id    (out_id),
        .out_sum   (out_sum),
        .out_exp   (out_exp),
        .out_nan   (out_nan),
        .out_inf   (out_inf),
        .out_sign  (out_sign)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_val(input logic [NAME_W-1:0] name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %0s %0s expected %h actual %h", name, field, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic read_vectors();
        int                fd;
        int                n;
        logic [8*256-1:0]  line;
        logic [NAME_W-1:0] tok;
        logic [63:0]       t_a;
        logic [63:0]       t_b;
        logic [31:0]       t_fmt;
        logic [31:0]       t_id;
        logic [31:0]       t_c;
        logic [31:0]       t_sum;
        logic [31:0]       t_exp;
        logic [31:0]       t_nan;
        logic [31:0]       t_inf;
        logic [31:0]       t_sign;
        fd = $fopen("bench/tcu_dot_vectors.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open the vector file");
            $display("TEST FAIL");
            $fatal(1, "missing vector file");
        end
        while (!$feof(fd)) begin
            line = '0;
            tok  = '0;
            n    = $fgets(line, fd);
            if (n > 0) begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", tok, t_fmt, t_id,
                            t_a, t_b, t_c, t_sum, t_exp, t_nan, t_inf, t_sign);
            end
            // Blank lines and lines opening with a lone # hold no request
            if (n > 0 && tok != "#") begin
                if (n != 11 || num_vec == MAX_VEC) begin
                    $display("error: vector line %0d is malformed or overflows the table",
                             num_vec + 1);
                    $display("TEST FAIL");
                    $fatal(1, "bad vector file");
                end else begin
                    v_name[num_vec] = tok;
                    v_fmt[num_vec]  = t_fmt[3:0];
                    v_id[num_vec]   = t_id[ID_W-1:0];
                    v_a[num_vec]    = t_a;
                    v_b[num_vec]    = t_b;
                    v_c[num_vec]    = t_c;
                    v_sum[num_vec]  = t_sum;
                    v_exp[num_vec]  = t_exp[EXP_W-1:0];
                    v_flag[num_vec] = {t_nan[0], t_inf[0], t_sign[0]};
                    num_vec++;
                end
            end
        end
        $fclose(fd);
        // Budget of 40 cycles per request on top of reset and drain
        cycle_limit = 40 * num_vec + 200;
    endtask

    // ========================================================================
    // Request driver
    // ========================================================================
    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_fmt    = '0;
        in_id     = '0;
        in_a      = '0;
        in_b      = '0;
        in_c      = '0;
        out_ready = 1'b0;
        rng_state = SEED;
        num_vec   = 0;
        sent      = 0;
        received  = 0;
        cycles    = 0;
        read_vectors();
        if (num_vec == 0) begin
            $display("error: the vector file holds no requests");
            $display("TEST FAIL");
            $fatal(1, "empty vector file");
        end
        repeat (10) @(posedge clk);
        #0.5;
        rst = 1'b0;
        while (sent < num_vec) begin
            @(posedge clk);
            #0.5;
            in_valid = 1'b1;
            in_fmt   = v_fmt[sent];
            in_id    = v_id[sent];
            in_a     = v_a[sent];
            in_b     = v_b[sent];
            in_c     = v_c[sent];
            // Handshake is settled by mid-cycle and holds until the edge
            @(negedge clk);
            if (in_ready) begin
                exp_q.push_back(sent);
                sent++;
            end
        end
        @(posedge clk);
        #0.5;
        in_valid = 1'b0;
        wait (received == num_vec);
        // Idle window that would expose a duplicated result
        repeat (20) @(posedge clk);
        @(negedge clk);
        // Drained pipeline holds no result and accepts new requests
        if (exp_q.size() == 0 && !out_valid && in_ready) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("error: DUT still busy after the last of %0d results", num_vec);
            $display("TEST FAIL");
            $fatal(1, "DUT not idle");
        end
    end

    // Random result back-pressure with ready on five cycles in eight
    always @(posedge clk) begin
        #0.5;
        rng_state = xorshift32(rng_state);
        out_ready = (rng_state[2:0] > 3'd2);
    end

    // ========================================================================
    // Result monitor and timeout
    // ========================================================================
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("error: DUT returned a result with no request outstanding");
                $display("TEST FAIL");
                $fatal(1, "unexpected result");
            end else begin
                head = exp_q.pop_front();
                check_val(v_name[head], "id", 32'(v_id[head]), 32'(out_id));
                check_val(v_name[head], "sum", v_sum[head], out_sum);
                check_val(v_name[head], "exp", 32'(v_exp[head]), 32'(out_exp));
                check_val(v_name[head], "nan", 32'(v_flag[head][2]), 32'(out_nan));
                check_val(v_name[head], "inf", 32'(v_flag[head][1]), 32'(out_inf));
                check_val(v_name[head], "sign", 32'(v_flag[head][0]), 32'(out_sign));
                received++;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("error: run passed %0d cycles with %0d of %0d results seen",
                     cycle_limit, received, num_vec);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

endmodule

// ==== bench/tcu_dot_vectors.txt ====
# name fmt id a b c then expected sum exp nan inf sign
# every field after the name is hex and lane 0 sits in the low bits of a and b
int8_ascending 8 01 0807060504030201 0101010101010101 00000000 00000024 000 0 0 0
int8_mixed_sign 8 02 807FFF01FE02FD03 7F8002FF03FE04FC 00000064 FFFF813F 000 0 0 0
int8_min_square 8 03 8080808080808080 8080808080808080 FFFFFFFB 0001FFFB 000 0 0 0
int8_c_large 8 04 0000000000000001 1122334455667788 00123456 001233DE 000 0 0 0
int8_cancel 8 05 FFFFFFFFFFFFFFFF 0102030405060708 00000024 00000000 000 0 0 0
int8_max_square 8 06 7F7F7F7F7F7F7F7F 7F7F7F7F7F7F7F7F 00000000 0001F808 000 0 0 0
fp16_lanes_only 1 07 BC003E0040003C00 38003E003C003C00 00000000 00260000 01F 0 0 0
fp16_c_truncate 1 08 00000000BC003C00 000000003C003C00 3F800000 007FFFFF 105 0 0 0
fp16_c_negative 1 09 3C003C003C003C00 3C003C003C003C00 C0200000 FF600000 106 0 0 0
fp16_c_subnormal 1 0A BC003E0040003C00 38003E003C003C00 00000001 00260000 01F 0 0 0
fp16_c_neg_zero 1 0B BC003E0040003C00 38003E003C003C00 80000000 00260000 01F 0 0 0
fp16_lane_subnormal 1 0C 0000000000013C00 000000003C003C00 00400000 00100000 01E 0 0 0
fp16_nan_operand 1 0D 0000000000007E00 0000000000003C00 00000000 00180000 02E 1 0 0
fp16_inf_times_zero 1 0E 000000003C007C00 000000003C000000 00000000 00100000 01E 1 0 0
fp16_neg_inf 1 0F 0000FC0000003C00 00003C0000004000 00000000 FFF00020 02E 0 1 1
fp16_pos_inf 1 10 FC00000000000000 BC00000000000000 00000000 00100000 02E 0 1 0
fp16_inf_opposed 1 11 0000000000007C00 0000000000003C00 FF800000 FF800000 185 1 0 0
fp16_c_neg_inf 1 12 0000000000003C00 0000000000003C00 FF800000 FF800000 185 0 1 1
fp16_c_nan 1 13 0000000000000000 0000000000000000 7FC00000 00C00000 185 1 0 0
fp16_c_mixed 1 14 38004000BC00BE00 380042003C003E00 40400000 00BFFFFE 106 0 0 0
fp16_floor_odd 1 15 0000000094013C00 000000003C013C00 00000000 000FFBFD 01E 0 0 0
int8_mixed_repeat 8 16 807FFF01FE02FD03 7F8002FF03FE04FC 00000064 FFFF813F 000 0 0 0
fp16_lanes_repeat 1 17 BC003E0040003C00 38003E003C003C00 00000000 00260000 01F 0 0 0

// ==== filelist.f ====
+incdir+include
hw/tcu_pkg.sv
hw/tcu_term_if.sv
hw/tcu_classifier.sv
hw/tcu_mul_lanes.sv
hw/tcu_term_fifo.sv
hw/tcu_mul_join.sv
hw/tcu_dot_accum.sv
hw/tcu_dot_top.sv
bench/tcu_dot_tb.sv
